// ==== design/eth_log_consts.svh ====
/*
	Script count, log word width and FIFO depths for the frame log
*/

`ifndef ETH_LOG_CONSTS_SVH
`define ETH_LOG_CONSTS_SVH

// Scripts evaluated in parallel by the upstream matcher
`define ETH_NUM_SCRIPTS 4

// Bits per packed log word, a multiple of 8
`define ETH_LOG_WIDTH 64

// Log words held before the host reader drains them
`define ETH_FRAME_FIFO_DEPTH 16

// Control records, one per captured frame
`define ETH_CTL_FIFO_DEPTH 4

`endif

// ==== design/eth_tag_pkg.sv ====
/*
	Types for the tagged input byte stream
	Per-script flags, full byte tag and script mask
*/

`default_nettype none

`include "eth_log_consts.svh"

package eth_tag_pkg;

	// Flags of one script for the current byte
	typedef struct packed {
		logic param;
		logic instr;
		logic matched;
	} script_flags_t;

	// Script 0 sits just above the FCS flag in bit 0
	typedef struct packed {
		script_flags_t [`ETH_NUM_SCRIPTS-1:0] scripts;
		logic fcs_invalid;
	} byte_tag_t;

	typedef logic [`ETH_NUM_SCRIPTS-1:0] script_mask_t;

endpackage

`default_nettype wire

// ==== design/eth_log_pkg.sv ====
/*
	Types for log words and control records
	Extractor state encoding
*/

`default_nettype none

`include "eth_log_consts.svh"

package eth_log_pkg;

	import eth_tag_pkg::*;

	typedef logic [`ETH_LOG_WIDTH-1:0] log_word_t;
	typedef logic [15:0] byte_count_t;
	typedef logic [63:0] timestamp_t;

	// Mask on top, timestamp at the bottom
	typedef struct packed {
		script_mask_t mask;
		byte_count_t size;
		timestamp_t timestamp;
	} ctl_record_t;

	typedef enum logic [1:0] {
		ST_WAIT_FIFO,
		ST_WRITE_FRAME,
		ST_WRITE_CTL,
		ST_OVERFLOW
	} extract_state_t;

endpackage

`default_nettype wire

// ==== design/eth_byte_if.sv ====
/*
	Tagged byte stream with source and sink modports
*/

`timescale 1ns/1ps
`default_nettype none

interface eth_byte_if import eth_tag_pkg::*; ();

	logic [7:0] data;
	byte_tag_t tag;
	logic last;
	logic valid;

	// No back-pressure, a byte counts whenever valid is high
	modport source (
		output data, tag, last, valid
	);

	modport sink (
		input data, tag, last, valid
	);

endinterface

`default_nettype wire

// ==== design/log_sync_fifo.sv ====
/*
	Single-clock first-word-fall-through FIFO
	Circular buffer with occupancy count, valid/ready on both sides
*/

`timescale 1ns/1ps
`default_nettype none

module log_sync_fifo #(
	parameter int WIDTH = 64,
	parameter int DEPTH = 16
) (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic [WIDTH-1:0] wr_data,
	input wire logic wr_valid,
	output logic wr_ready,

	output logic [WIDTH-1:0] rd_data,
	output logic rd_valid,
	input wire logic rd_ready
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_wr;
	logic do_rd;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign wr_ready = (count != CNT_W'(DEPTH));
	assign rd_valid = (count != '0);
	// Head word is visible before it is popped
	assign rd_data = mem[rd_ptr];

	assign do_wr = wr_valid & wr_ready;
	assign do_rd = rd_valid & rd_ready;

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
		count <= CNT_W'(DEPTH));

endmodule

`default_nettype wire

// ==== design/eth_frame_loop_extract.sv ====
/*
	Frame extractor with flag decode, capture FSM and word packer
	Builds one control record per frame and counts dropped frames
*/

`timescale 1ns/1ps
`default_nettype none

`include "eth_log_consts.svh"

module eth_frame_loop_extract import eth_tag_pkg::*, eth_log_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic srst,
	input wire logic enable,
	input wire timestamp_t current_time,

	eth_byte_if.sink byte_in,

	output log_word_t frame_data,
	output logic frame_valid,
	input wire logic frame_ready,

	output ctl_record_t ctl_data,
	output logic ctl_valid,
	input wire logic ctl_ready,

	output logic [63:0] overflow_count
);

	localparam int LANES = `ETH_LOG_WIDTH / 8;
	localparam int LANE_W = $clog2(LANES);

	extract_state_t state;
	logic in_frame;
	byte_count_t byte_cnt;
	logic [`ETH_LOG_WIDTH-9:0] byte_sr;

	script_mask_t script_match;
	script_mask_t extract_hits;
	logic extract_byte;
	logic [LANE_W-1:0] lane;
	logic [LANE_W+2:0] flush_shift;
	logic [7:0] flush_top;
	log_word_t flush_word;
	byte_count_t size_next;
	logic capture;
	logic word_due;
	logic word_drop;
	logic drop_frame;

	always_comb begin
		for (int i = 0; i < `ETH_NUM_SCRIPTS; i++) begin
			script_match[i] = byte_in.tag.scripts[i].matched;
			extract_hits[i] = byte_in.tag.scripts[i].matched &
				byte_in.tag.scripts[i].instr;
		end
	end

	assign extract_byte = |extract_hits;

	// Low bits of the byte count index the next free lane
	assign lane = byte_cnt[LANE_W-1:0];
	assign size_next = byte_cnt + byte_count_t'(extract_byte);

	// Held bytes sit in the top lanes of byte_sr and shift down to lane 0
	assign flush_top = extract_byte ? byte_in.data : 8'h00;
	assign flush_shift = {~lane, 3'b000};
	assign flush_word = {flush_top, byte_sr} >> flush_shift;

	assign capture = (state == ST_WRITE_FRAME) & byte_in.valid;
	assign word_due = capture & ((extract_byte & (&lane)) |
		(byte_in.last & (extract_byte | (lane != '0))));
	assign word_drop = word_due & ~frame_ready;

	// Frame ends outside capture or loses a word to a full FIFO
	assign drop_frame = byte_in.valid & byte_in.last &
		((state != ST_WRITE_FRAME) | word_drop);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_WAIT_FIFO;
			in_frame <= 1'b0;
			byte_cnt <= '0;
			frame_valid <= 1'b0;
			ctl_valid <= 1'b0;
		end else begin
			if (frame_valid & frame_ready) begin
				frame_valid <= 1'b0;
			end
			if (ctl_valid & ctl_ready) begin
				ctl_valid <= 1'b0;
			end
			if (byte_in.valid) begin
				in_frame <= ~byte_in.last;
			end

			case (state)
				ST_WAIT_FIFO: begin
					byte_cnt <= '0;
					if (enable & frame_ready & ctl_ready &
						~in_frame & ~byte_in.valid) begin
						state <= ST_WRITE_FRAME;
					end
				end

				ST_WRITE_FRAME: begin
					if (byte_in.valid) begin
						if (extract_byte) begin
							byte_cnt <= size_next;
						end
						if (word_due) begin
							if (frame_ready) begin
								frame_data <= flush_word;
								frame_valid <= 1'b1;
							end else begin
								state <= ST_OVERFLOW;
							end
						end
						if (byte_in.last) begin
							state <= ST_WRITE_CTL;
							ctl_valid <= 1'b1;
							ctl_data.mask <= word_drop ? '0 : script_match;
							ctl_data.size <= size_next;
							ctl_data.timestamp <= current_time;
						end
					end else if (~in_frame & ~enable) begin
						state <= ST_WAIT_FIFO;
					end
				end

				ST_WRITE_CTL: begin
					if (ctl_valid & ctl_ready) begin
						state <= ST_WAIT_FIFO;
					end
				end

				ST_OVERFLOW: begin
					// Size stays frozen at the point of the drop
					if (byte_in.valid & byte_in.last) begin
						state <= ST_WRITE_CTL;
						ctl_valid <= 1'b1;
						ctl_data.mask <= '0;
						ctl_data.size <= byte_cnt;
						ctl_data.timestamp <= current_time;
					end
				end

				default: state <= ST_WAIT_FIFO;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (capture & extract_byte) begin
			byte_sr <= {byte_in.data, byte_sr[`ETH_LOG_WIDTH-9:8]};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			overflow_count <= 64'd0;
		end else if (srst) begin
			overflow_count <= 64'd0;
		end else if (drop_frame) begin
			overflow_count <= overflow_count + 64'd1;
		end
	end

	a_frame_hold: assert property (@(posedge clk) disable iff (!rst_n)
		frame_valid && !frame_ready |=> frame_valid && $stable(frame_data));

	a_ctl_pending: assert property (@(posedge clk) disable iff (!rst_n)
		state == ST_WRITE_CTL |-> ctl_valid);

endmodule

`default_nettype wire

// ==== design/eth_frame_log.sv ====
/*
	Frame log capture top: byte interface, extractor, word and record FIFOs
*/

`timescale 1ns/1ps
`default_nettype none

`include "eth_log_consts.svh"

module eth_frame_log import eth_tag_pkg::*, eth_log_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic srst,
	input wire logic enable,
	input wire timestamp_t current_time,

	input wire logic [7:0] s_data,
	input wire byte_tag_t s_tag,
	input wire logic s_last,
	input wire logic s_valid,

	output log_word_t m_frame_data,
	output logic m_frame_valid,
	input wire logic m_frame_ready,

	output ctl_record_t m_ctl_data,
	output logic m_ctl_valid,
	input wire logic m_ctl_ready,

	output logic [63:0] overflow_count
);

	log_word_t frame_wr_data;
	logic frame_wr_valid;
	logic frame_wr_ready;
	ctl_record_t ctl_wr_data;
	logic ctl_wr_valid;
	logic ctl_wr_ready;

	eth_byte_if byte_bus ();

	assign byte_bus.data = s_data;
	assign byte_bus.tag = s_tag;
	assign byte_bus.last = s_last;
	assign byte_bus.valid = s_valid;

	// Records leave ST_WRITE_CTL as soon as ctl_fifo accepts them
	eth_frame_loop_extract extract (
		.clk(clk),
		.rst_n(rst_n),
		.srst(srst),
		.enable(enable),
		.current_time(current_time),
		.byte_in(byte_bus.sink),
		.frame_data(frame_wr_data),
		.frame_valid(frame_wr_valid),
		.frame_ready(frame_wr_ready),
		.ctl_data(ctl_wr_data),
		.ctl_valid(ctl_wr_valid),
		.ctl_ready(ctl_wr_ready),
		.overflow_count(overflow_count)
	);

	log_sync_fifo #(
		.WIDTH($bits(log_word_t)),
		.DEPTH(`ETH_FRAME_FIFO_DEPTH)
	) frame_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr_data(frame_wr_data),
		.wr_valid(frame_wr_valid),
		.wr_ready(frame_wr_ready),
		.rd_data(m_frame_data),
		.rd_valid(m_frame_valid),
		.rd_ready(m_frame_ready)
	);

	log_sync_fifo #(
		.WIDTH($bits(ctl_record_t)),
		.DEPTH(`ETH_CTL_FIFO_DEPTH)
	) ctl_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr_data(ctl_wr_data),
		.wr_valid(ctl_wr_valid),
		.wr_ready(ctl_wr_ready),
		.rd_data(m_ctl_data),
		.rd_valid(m_ctl_valid),
		.rd_ready(m_ctl_ready)
	);

endmodule

`default_nettype wire

// ==== verif/eth_frame_log_frames.svh ====
/*
	Test frame table: flag patterns, ready levels and expected results
*/

`ifndef ETH_FRAME_LOG_FRAMES_SVH
`define ETH_FRAME_LOG_FRAMES_SVH

localparam int NUM_CASES = 6;

// Non-last byte i takes the b flags when sel[i % 16] is set, otherwise the a flags
typedef struct packed {
	int len;
	logic [15:0] sel;
	script_mask_t a_match;
	script_mask_t a_instr;
	script_mask_t b_match;
	script_mask_t b_instr;
	script_mask_t last_match;
	script_mask_t last_instr;
	bit en;
	bit frame_rdy;
	bit ctl_rdy;
	int exp_words;
	bit exp_rec;
	script_mask_t exp_mask;
	int exp_size;
	int exp_ovf;
	bit clear_after;
} frame_case_t;

// len, sel, a match/instr, b match/instr, last match/instr, enable, frame/ctl ready
// then words, record present, mask, size, overflow delta, srst afterwards
frame_case_t cases [NUM_CASES] = '{
	'{20, 16'h0000, 4'h1, 4'h1, 4'h1, 4'h1, 4'h3, 4'h1, 1'b1, 1'b1, 1'b1,
		3, 1'b1, 4'h3, 20, 0, 1'b0},
	'{13, 16'h6d5a, 4'h4, 4'h2, 4'ha, 4'h8, 4'h6, 4'h4, 1'b1, 1'b1, 1'b1,
		1, 1'b1, 4'h6, 8, 0, 1'b0},
	'{10, 16'h00f0, 4'h1, 4'h0, 4'h0, 4'hf, 4'h9, 4'h6, 1'b1, 1'b1, 1'b1,
		0, 1'b1, 4'h9, 0, 0, 1'b0},
	'{12, 16'h0000, 4'h1, 4'h1, 4'h1, 4'h1, 4'h1, 4'h1, 1'b0, 1'b1, 1'b1,
		0, 1'b0, 4'h0, 0, 1, 1'b1},
	// Word 17 finds the FIFO full at byte 136
	'{200, 16'h0000, 4'h2, 4'h2, 4'h2, 4'h2, 4'h2, 4'h2, 1'b1, 1'b0, 1'b1,
		16, 1'b1, 4'h0, 136, 1, 1'b0},
	'{5, 16'h0003, 4'h8, 4'h0, 4'hc, 4'h4, 4'h1, 4'h1, 1'b1, 1'b1, 1'b0,
		1, 1'b1, 4'h1, 3, 0, 1'b0}
};

string case_name [NUM_CASES] = '{
	"all bytes extracted",
	"mixed flags",
	"no extracted bytes",
	"enable low",
	"word FIFO full",
	"timestamp"
};

`endif

// ==== verif/eth_frame_log_tb.sv ====
/*
	Testbench for the frame log capture top
	Table-driven frames, byte model for log words, record and overflow checks
*/

`timescale 1ns/1ps
`default_nettype none

`include "eth_log_consts.svh"

module eth_frame_log_tb import eth_tag_pkg::*, eth_log_pkg::*; ();

	logic clk = 1'b0;
	logic rst_n;
	logic srst;
	logic enable;
	timestamp_t current_time;
	logic [7:0] s_data;
	byte_tag_t s_tag;
	logic s_last;
	logic s_valid;
	log_word_t m_frame_data;
	logic m_frame_valid;
	logic m_frame_ready;
	ctl_record_t m_ctl_data;
	logic m_ctl_valid;
	logic m_ctl_ready;
	logic [63:0] overflow_count;

	log_word_t got_words [$];
	ctl_record_t got_recs [$];
	logic [31:0] lfsr_state;
	int errors = 0;
	int tests_run = 0;
	int failed_tests = 0;
	bit aborted = 1'b0;

	`include "eth_frame_log_frames.svh"

	eth_frame_log uut (.*);

	always #5 clk = ~clk;

	// Handshakes sampled at the falling edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (m_frame_valid && m_frame_ready) begin
				got_words.push_back(m_frame_data);
			end
			if (m_ctl_valid && m_ctl_ready) begin
				got_recs.push_back(m_ctl_data);
			end
		end
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out) begin
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		end
		return out;
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[6:0], lfsr_bit()};
		end
		return v;
	endfunction

	function automatic byte_tag_t make_tag(input script_mask_t m_flags,
		input script_mask_t i_flags, input script_mask_t p_flags, input logic fcs);
		byte_tag_t t;
		for (int s = 0; s < `ETH_NUM_SCRIPTS; s++) begin
			t.scripts[s].matched = m_flags[s];
			t.scripts[s].instr = i_flags[s];
			t.scripts[s].param = p_flags[s];
		end
		t.fcs_invalid = fcs;
		return t;
	endfunction

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("error at %0t: %s is %0h, expected %0h",
				$time, what, got, exp);
		end
	endtask

	task automatic drive_idle(input int cycles);
		for (int k = 0; k < cycles; k++) begin
			@(posedge clk);
			#1;
			s_valid = 1'b0;
			s_last = 1'b0;
		end
	endtask

	task automatic wait_outputs(input int n_words, output bit ok);
		int cycles;
		cycles = 0;
		while ((got_words.size() < n_words || got_recs.size() < 1) &&
			cycles < 200) begin
			@(posedge clk);
			cycles++;
		end
		ok = (got_words.size() >= n_words) && (got_recs.size() >= 1);
	endtask

	task automatic run_case(input int idx);
		frame_case_t c;
		logic [7:0] exp_bytes [$];
		script_mask_t m_flags;
		script_mask_t i_flags;
		logic [63:0] ovf_before;
		timestamp_t last_time;
		log_word_t exp_word;
		int errs_before;
		bit ok;
		c = cases[idx];
		tests_run++;
		errs_before = errors;
		got_words.delete();
		got_recs.delete();
		@(posedge clk);
		#1;
		enable = c.en;
		m_frame_ready = c.frame_rdy;
		m_ctl_ready = c.ctl_rdy;
		drive_idle(8);
		ovf_before = overflow_count;

		for (int b = 0; b < c.len; b++) begin
			if (b == c.len - 1) begin
				m_flags = c.last_match;
				i_flags = c.last_instr;
			end else if (c.sel[4'(b)]) begin
				m_flags = c.b_match;
				i_flags = c.b_instr;
			end else begin
				m_flags = c.a_match;
				i_flags = c.a_instr;
			end
			@(posedge clk);
			#1;
			s_data = rand_bits(8);
			s_tag = make_tag(m_flags, i_flags, script_mask_t'(rand_bits(4)),
				lfsr_bit());
			s_last = (b == c.len - 1);
			s_valid = 1'b1;
			current_time = current_time + 64'd3;
			last_time = current_time;
			// Reference model keeps bytes where some script has matched and instr set
			if ((m_flags & i_flags) != '0) begin
				exp_bytes.push_back(s_data);
			end
		end

		drive_idle(1);
		m_frame_ready = 1'b1;
		m_ctl_ready = 1'b1;
		if (c.exp_rec) begin
			wait_outputs(c.exp_words, ok);
			if (!ok) begin
				$display("timeout: test %0d did not see its words and record in 200 cycles",
					idx);
				errors++;
				failed_tests++;
				aborted = 1'b1;
				return;
			end
		end
		// Settle so that any extra word or record shows up
		drive_idle(20);

		check_value("word count", 64'(got_words.size()), 64'(c.exp_words));
		for (int w = 0; w < got_words.size() && w < c.exp_words; w++) begin
			exp_word = '0;
			for (int l = 0; l < 8; l++) begin
				if (w * 8 + l < exp_bytes.size()) begin
					exp_word[l*8 +: 8] = exp_bytes[w * 8 + l];
				end
			end
			check_value($sformatf("word %0d", w), got_words[w], exp_word);
		end
		check_value("record count", 64'(got_recs.size()),
			c.exp_rec ? 64'd1 : 64'd0);
		if (c.exp_rec && got_recs.size() != 0) begin
			check_value("record mask", 64'(got_recs[0].mask), 64'(c.exp_mask));
			check_value("record size", 64'(got_recs[0].size), 64'(c.exp_size));
			check_value("record timestamp", got_recs[0].timestamp, last_time);
		end
		check_value("overflow count", overflow_count, ovf_before + 64'(c.exp_ovf));

		if (c.clear_after) begin
			@(posedge clk);
			#1;
			srst = 1'b1;
			@(posedge clk);
			#1;
			srst = 1'b0;
			check_value("overflow count after clear", overflow_count, 64'd0);
		end

		if (errors != errs_before) begin
			failed_tests++;
		end
		$display("test %0d %s: %s", idx, case_name[idx],
			(errors == errs_before) ? "ok" : "mismatches found");
	endtask

	initial begin
		lfsr_state = 32'h0da1_31f1;
		rst_n = 1'b0;
		srst = 1'b0;
		enable = 1'b0;
		current_time = 64'h0000_1000_0000_0000;
		s_data = '0;
		s_tag = '0;
		s_last = 1'b0;
		s_valid = 1'b0;
		m_frame_ready = 1'b0;
		m_ctl_ready = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;

		for (int i = 0; i < NUM_CASES && !aborted; i++) begin
			run_case(i);
		end

		$display("%0d tests run, %0d failed, %0d errors",
			tests_run, failed_tests, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== eth_frame_log.f ====
+incdir+design
+incdir+verif
design/eth_tag_pkg.sv
design/eth_log_pkg.sv
design/eth_byte_if.sv
design/log_sync_fifo.sv
design/eth_frame_loop_extract.sv
design/eth_frame_log.sv
verif/eth_frame_log_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the frame log testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module eth_frame_log_tb -f eth_frame_log.f \
	-Mdir obj_dir -o eth_frame_log_sim \
	&& ./obj_dir/eth_frame_log_sim | tee sim.log \
	|| echo "build or simulation run did not complete"

grep -qx "Simulation passed" sim.log && echo "RESULT: PASS" \
	|| { echo "RESULT: FAIL"; exit 1; }
